//--- common/qla_config.svh
// ----------------------------------------------------------
// qla configuration macros
// host address map, write field bit positions, axis count
// ----------------------------------------------------------
`ifndef QLA_CONFIG_SVH
`define QLA_CONFIG_SVH

// board size
`define QLA_NUM_CHAN        4           // motor axes on the board

// ----------------------------------------------------------
// address map
// block in addr[15:12], channel in addr[7:4], offset in addr[3:0]
// ----------------------------------------------------------
`define ADDR_MAIN           4'd0        // main register block
`define REG_STATUS          4'd0        // board status, channel 0 only
`define OFF_DAC_CTRL        4'd1        // commanded current
`define OFF_MOTOR_STATUS    4'd12       // amp control and status

// ----------------------------------------------------------
// write data fields
// ----------------------------------------------------------
// status register write
`define PWR_EN_MASK_BIT     19          // write touches power enable
`define PWR_EN_BIT          18          // new power enable value

// motor status write
`define AMP_EN_MASK_BIT     30          // write touches amp enable
`define AMP_EN_BIT          29          // new amp enable value

`endif

//--- common/qla_pkg.sv
// ----------------------------------------------------------
// qla types
// host write bus, per-axis state and the dac command word
// ----------------------------------------------------------
`include "qla_config.svh"

package qla_pkg;

    // ------------------------------------------------------
    // host register bus, write side
    // ------------------------------------------------------
    typedef struct packed {
        logic [15:0] waddr;     // block/channel/offset
        logic [31:0] wdata;
        logic        wen;       // single quadlet write strobe
        logic        blk_wen;   // high during block writes
    } reg_wr_t;

    // ------------------------------------------------------
    // motor channel state
    // ------------------------------------------------------
    typedef struct packed {
        logic amp_en;           // host amp enable
        logic safety_dis;       // latched safety disable
        logic amp_ok;           // fault pin, 1 = amp on
    } motor_stat_t;

    // everything one axis exports
    typedef struct packed {
        logic [15:0] cur_cmd;   // commanded current
        motor_stat_t stat;
    } chan_out_t;

    // ------------------------------------------------------
    // dac port
    // ------------------------------------------------------
    // cur[0] is axis 1, cur[3] is axis 4
    typedef struct packed {
        logic [`QLA_NUM_CHAN-1:0][15:0] cur;
    } dac_cmd_t;

endpackage

//--- files.f
+incdir+common
common/qla_pkg.sv
motor/motor_channel.sv
src/board_regs.sv
src/dac_update.sv
src/reg_read_mux.sv
src/qla_top.sv
testbench/tb_clock.sv
testbench/tb_qla.sv

//--- motor/motor_channel.sv
// ----------------------------------------------------------
// motor channel
// one axis: commanded current, amp enable, safety latch
// ----------------------------------------------------------
`include "qla_config.svh"

module motor_channel #(
    parameter int unsigned CHANNEL = 1          // axis number, 1 to 4
) (
    input  logic               sysclk,
    input  logic               rst_n,
    input  qla_pkg::reg_wr_t   reg_wr,
    input  logic               pwr_enable,      // board power from board_regs
    input  logic               amp_fault_n,     // 1 = amp on, 0 = fault
    input  logic               wdog_timeout,
    output qla_pkg::chan_out_t chan_out,
    output logic               amp_disable,     // to amp pin, active high
    output logic               amp_cmd,         // amp enable write this cycle
    output logic               cmd_blk_wr       // block write of cur_cmd
);

    logic        chan_hit;      // write aimed at this axis
    logic        cur_wr;        // cur_cmd write
    logic        fault_trip;    // safety set condition
    logic [15:0] cur_cmd_q;
    logic        amp_en_q;
    logic        safety_dis_q;

    // ------------------------------------------------------
    // write decode
    // ------------------------------------------------------
    assign chan_hit = reg_wr.wen
                   && (reg_wr.waddr[15:12] == `ADDR_MAIN)
                   && (reg_wr.waddr[7:4] == 4'(CHANNEL));

    assign cur_wr     = chan_hit && (reg_wr.waddr[3:0] == `OFF_DAC_CTRL);
    assign cmd_blk_wr = cur_wr && reg_wr.blk_wen;    // only block writes go to dac

    // mask bit selects whether amp enable is touched at all
    assign amp_cmd = chan_hit
                  && (reg_wr.waddr[3:0] == `OFF_MOTOR_STATUS)
                  && reg_wr.wdata[`AMP_EN_MASK_BIT];

    // ------------------------------------------------------
    // registers
    // ------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cur_cmd_q <= '0;        // host reads back zero after reset
        end else if (cur_wr) begin
            cur_cmd_q <= reg_wr.wdata[15:0];
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            amp_en_q <= 1'b0;
        end else if (amp_cmd) begin
            amp_en_q <= reg_wr.wdata[`AMP_EN_BIT];
        end
    end

    // fault only counts while the amp is meant to be on
    assign fault_trip = (!amp_fault_n && amp_en_q) || wdog_timeout;

    // safety latch, set wins over clear
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            safety_dis_q <= 1'b0;
        end else if (fault_trip) begin
            safety_dis_q <= 1'b1;
        end else if (amp_cmd && reg_wr.wdata[`AMP_EN_BIT]) begin
            safety_dis_q <= 1'b0;   // host re-enable clears it
        end
    end

    // ------------------------------------------------------
    // outputs
    // ------------------------------------------------------
    assign amp_disable = !(pwr_enable && amp_en_q && !safety_dis_q);

    assign chan_out.cur_cmd         = cur_cmd_q;
    assign chan_out.stat.amp_en     = amp_en_q;
    assign chan_out.stat.safety_dis = safety_dis_q;
    assign chan_out.stat.amp_ok     = amp_fault_n;   // raw pin

    // no amp may drive without board power
    a_no_pwr_no_amp : assert property (
        @(posedge sysclk) disable iff (!rst_n)
        !pwr_enable |-> amp_disable
    );

endmodule

//--- run.sh
#!/bin/sh
# build the qla testbench with verilator, run it, look for the pass line
verilator --binary --timing --assert -f files.f --top-module tb_qla -Mdir obj_dir -o sim_qla \
    && ./obj_dir/sim_qla | tee /dev/stderr | grep -qF "TEST RESULT: PASS" \
    && echo "qla simulation passed" \
    || { echo "qla simulation failed" >&2; exit 1; }

//--- src/board_regs.sv
// ----------------------------------------------------------
// board registers
// global status word, board power enable, watchdog clear
// ----------------------------------------------------------
`include "qla_config.svh"

module board_regs (
    input  logic                     sysclk,
    input  logic                     rst_n,
    input  qla_pkg::reg_wr_t         reg_wr,
    input  logic [3:0]               board_id,
    input  logic                     wdog_timeout,
    input  qla_pkg::motor_stat_t     chan_stat [`QLA_NUM_CHAN],
    input  logic [`QLA_NUM_CHAN-1:0] amp_cmd,       // amp enable writes
    output logic                     pwr_enable,
    output logic                     wdog_clear,    // one cycle pulse
    output logic [31:0]              status_word
);

    logic status_wr;    // write to chan 0 status reg
    logic pwr_cmd;      // power enable command

    // ------------------------------------------------------
    // write decode
    // ------------------------------------------------------
    assign status_wr = reg_wr.wen
                    && (reg_wr.waddr[15:12] == `ADDR_MAIN)
                    && (reg_wr.waddr[7:4] == 4'd0)
                    && (reg_wr.waddr[3:0] == `REG_STATUS);

    assign pwr_cmd = status_wr && reg_wr.wdata[`PWR_EN_MASK_BIT];

    // board power enable
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            pwr_enable <= 1'b0;
        end else if (pwr_cmd) begin
            pwr_enable <= reg_wr.wdata[`PWR_EN_BIT];
        end
    end

    // any power or amp command restarts the watchdog
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wdog_clear <= 1'b0;
        end else begin
            wdog_clear <= pwr_cmd || (|amp_cmd);
        end
    end

    // ------------------------------------------------------
    // status word
    // ------------------------------------------------------
    always_comb begin
        status_word                = '0;
        status_word[27:24]         = board_id;
        status_word[23]            = wdog_timeout;
        status_word[`PWR_EN_BIT]   = pwr_enable;     // bit 18
        // per-axis bits, axis 1 in the low bit of each nibble
        for (int i = 0; i < `QLA_NUM_CHAN; i++) begin
            status_word[8 + i] = chan_stat[i].amp_ok;
            status_word[4 + i] = chan_stat[i].safety_dis;
            status_word[i]     = chan_stat[i].amp_en;
        end
    end

endmodule

//--- src/dac_update.sv
// ----------------------------------------------------------
// dac update request
// holds valid from a block write until the dac takes it
// ----------------------------------------------------------
`include "qla_config.svh"

module dac_update (
    input  logic                     sysclk,
    input  logic                     rst_n,
    input  logic [`QLA_NUM_CHAN-1:0] cmd_blk_wr,   // per axis block write
    input  logic                     dac_ready,
    output logic                     dac_valid
);

    logic new_req;      // some axis got a block write
    logic xfer;         // handshake completes this edge

    assign new_req = |cmd_blk_wr;
    assign xfer    = dac_valid && dac_ready;

    // ------------------------------------------------------
    // request register
    // ------------------------------------------------------
    // data comes live from the axes, so a write while pending
    // only refreshes the payload and needs no second request
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            dac_valid <= 1'b0;
        end else if (new_req) begin
            dac_valid <= 1'b1;      // also re-arms on the transfer edge
        end else if (xfer) begin
            dac_valid <= 1'b0;
        end
    end

    // ------------------------------------------------------
    // handshake rule
    // ------------------------------------------------------
    // valid never drops under back-pressure
    a_valid_hold : assert property (
        @(posedge sysclk) disable iff (!rst_n)
        dac_valid && !dac_ready |=> dac_valid
    );

endmodule

//--- src/qla_top.sv
// ----------------------------------------------------------
// qla top level
// board regs, four motor axes, dac request and read mux
// ----------------------------------------------------------
`include "qla_config.svh"

module qla_top (
    input  logic                     sysclk,
    input  logic                     rst_n,
    input  logic [3:0]               board_id,      // rotary switch
    // host register bus
    input  qla_pkg::reg_wr_t         reg_wr,
    input  logic [15:0]              reg_raddr,
    output logic [31:0]              reg_rdata,
    // amplifiers and watchdog
    input  logic [`QLA_NUM_CHAN-1:0] amp_fault_n,   // 1 = amp on
    input  logic                     wdog_timeout,
    output logic                     wdog_clear,
    output logic                     pwr_enable,
    output logic [`QLA_NUM_CHAN-1:0] amp_disable,
    // dac port, valid/ready
    output qla_pkg::dac_cmd_t        dac_data,
    output logic                     dac_valid,
    input  logic                     dac_ready
);
    import qla_pkg::*;

    chan_out_t                chans     [`QLA_NUM_CHAN];
    motor_stat_t              chan_stat [`QLA_NUM_CHAN];
    logic [`QLA_NUM_CHAN-1:0] amp_cmd;      // amp enable write, per axis
    logic [`QLA_NUM_CHAN-1:0] cmd_blk_wr;   // block write of cur_cmd, per axis
    logic [31:0]              status_word;

    // ------------------------------------------------------
    // global registers, channel 0
    // ------------------------------------------------------
    board_regs u_board_regs (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .reg_wr      (reg_wr),
        .board_id    (board_id),
        .wdog_timeout(wdog_timeout),
        .chan_stat   (chan_stat),
        .amp_cmd     (amp_cmd),
        .pwr_enable  (pwr_enable),
        .wdog_clear  (wdog_clear),
        .status_word (status_word)
    );

    // ------------------------------------------------------
    // motor axes 1..4
    // ------------------------------------------------------
    for (genvar i = 0; i < `QLA_NUM_CHAN; i++) begin : g_chan
        motor_channel #(.CHANNEL(i + 1)) u_chan (
            .sysclk      (sysclk),
            .rst_n       (rst_n),
            .reg_wr      (reg_wr),
            .pwr_enable  (pwr_enable),
            .amp_fault_n (amp_fault_n[i]),
            .wdog_timeout(wdog_timeout),
            .chan_out    (chans[i]),
            .amp_disable (amp_disable[i]),
            .amp_cmd     (amp_cmd[i]),
            .cmd_blk_wr  (cmd_blk_wr[i])
        );

        assign chan_stat[i]    = chans[i].stat;
        assign dac_data.cur[i] = chans[i].cur_cmd;   // live host command
    end

    // dac request, one outstanding at most
    dac_update u_dac_update (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .cmd_blk_wr(cmd_blk_wr),
        .dac_ready (dac_ready),
        .dac_valid (dac_valid)
    );

    reg_read_mux u_read_mux (
        .reg_raddr  (reg_raddr),
        .status_word(status_word),
        .chans      (chans),
        .reg_rdata  (reg_rdata)
    );

endmodule

//--- src/reg_read_mux.sv
// ----------------------------------------------------------
// register read mux
// decodes the read address, returns status or axis data
// ----------------------------------------------------------
`include "qla_config.svh"

module reg_read_mux (
    input  logic [15:0]        reg_raddr,
    input  logic [31:0]        status_word,
    input  qla_pkg::chan_out_t chans [`QLA_NUM_CHAN],
    output logic [31:0]        reg_rdata
);

    localparam int IDX_W = $clog2(`QLA_NUM_CHAN);

    logic [3:0]       blk;      // addr[15:12]
    logic [3:0]       chan;     // addr[7:4]
    logic [3:0]       off;      // addr[3:0]
    logic [IDX_W-1:0] idx;      // axis array index

    assign blk  = reg_raddr[15:12];
    assign chan = reg_raddr[7:4];
    assign off  = reg_raddr[3:0];
    assign idx  = IDX_W'(chan - 4'd1);     // axis 1 at index 0

    always_comb begin
        reg_rdata = '0;     // unmapped reads give zero
        if (blk == `ADDR_MAIN) begin
            if (chan == 4'd0) begin
                if (off == `REG_STATUS) begin
                    reg_rdata = status_word;
                end
            end else if (chan <= 4'(`QLA_NUM_CHAN)) begin
                case (off)
                    `OFF_DAC_CTRL: begin
                        reg_rdata = {16'd0, chans[idx].cur_cmd};
                    end
                    `OFF_MOTOR_STATUS: begin
                        reg_rdata[`AMP_EN_BIT] = chans[idx].stat.amp_en;
                        reg_rdata[17]          = chans[idx].stat.safety_dis;
                        reg_rdata[16]          = chans[idx].stat.amp_ok;
                    end
                    default: begin
                        reg_rdata = '0;
                    end
                endcase
            end
        end
    end

endmodule

//--- testbench/tb_clock.sv
// ----------------------------------------------------------
// testbench clock and reset
// 8 unit clock period, reset held low for 8 rising edges
// ----------------------------------------------------------
module tb_clock (
    output logic sysclk,
    output logic rst_n
);

    initial begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;    // period 8
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge sysclk);   // sync reset seen on 8 edges
        @(negedge sysclk);
        rst_n = 1'b1;                   // release away from the sampling edge
    end

endmodule

//--- testbench/tb_qla.sv
// ----------------------------------------------------------
// qla testbench
// table of register writes, reads and pin states run against
// a reference model of the board, one clock per step
// ----------------------------------------------------------
`include "qla_config.svh"

module tb_qla;
    import qla_pkg::*;

    localparam logic [3:0]  BOARD_ID = 4'hA;
    localparam logic [3:0]  PIN_OK   = 4'hF;                             // all amps on
    localparam logic [1:0]  W_NONE = 2'b00, W_SGL = 2'b10, W_BLK = 2'b11;  // {wen, blk_wen}
    localparam logic [1:0]  C_IDLE = 2'b00, C_RDY = 2'b01, C_WDOG = 2'b10; // {wdog, ready}
    localparam logic [31:0] PWR_ON = 32'h000C_0000, PWR_OFF = 32'h0008_0000; // mask bit 19
    localparam logic [31:0] AMP_ON = 32'h6000_0000, AMP_OFF = 32'h4000_0000; // mask bit 30

    typedef struct packed {
        logic [1:0]  wmode;         // {wen, blk_wen}
        logic [15:0] waddr;
        logic [31:0] wdata;
        logic [15:0] raddr;
        logic [3:0]  fault_n;
        logic [1:0]  ctl;           // {wdog_timeout, dac_ready}
        logic [31:0] exp_rdata;
        logic [3:0]  exp_amp_dis;
        logic [2:0]  exp_flags;     // {pwr_enable, wdog_clear, dac_valid}
        logic [63:0] exp_dac;
    } step_t;

    logic sysclk, rst_n, wdog_timeout, wdog_clear, pwr_enable, dac_valid, dac_ready;
    logic [3:0]  board_id, amp_fault_n, amp_disable;
    logic [15:0] reg_raddr;
    logic [31:0] reg_rdata;
    reg_wr_t     reg_wr;
    dac_cmd_t    dac_data;

    step_t       steps [$];
    string       names [$];
    logic [15:0] lfsr;
    logic [15:0] m_cur [4];     // model commanded currents
    logic [3:0]  m_amp_en, m_safe;
    logic        m_pwr, m_valid;
    int          cycles = 0;
    int          cycle_limit = 0;

    tb_clock clk0 (.sysclk(sysclk), .rst_n(rst_n));
    qla_top dut0 (.*);

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_next(lfsr);             // one step per bit
            w    = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic logic [15:0] reg_addr(input int ch, input int off);
        return {`ADDR_MAIN, 4'd0, 4'(ch), 4'(off)};
    endfunction

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    // ------------------------------------------------------------
    // reference model advanced one edge per table step
    // ------------------------------------------------------------
    task automatic add_step(input string name, input logic [1:0] wmode,
                            input logic [15:0] waddr, input logic [31:0] wdata,
                            input logic [15:0] raddr, input logic [3:0] fault_n,
                            input logic [1:0] ctl);
        step_t       s;
        int          wc;
        int          rc;
        logic        main_wr;
        logic        pwr_cmd;
        logic        req;
        logic [3:0]  amp_cmd;
        logic [3:0]  trip;
        logic [31:0] rd;

        main_wr = wmode[1] && (waddr[15:12] == 4'd0);
        wc      = int'(waddr[7:4]);
        rc      = int'(raddr[7:4]);
        pwr_cmd = main_wr && wc == 0 && waddr[3:0] == 4'd0 && wdata[19];
        req     = 1'b0;
        amp_cmd = '0;
        trip    = {4{ctl[1]}} | (~fault_n & m_amp_en);     // amp enable before the edge
        if (main_wr && wc >= 1 && wc <= 4) begin
            if (waddr[3:0] == 4'd1) begin
                m_cur[wc - 1] = wdata[15:0];
                req = wmode[0];                             // block writes only
            end
            amp_cmd[wc - 1] = (waddr[3:0] == 4'd12) && wdata[30];
        end
        for (int i = 0; i < 4; i++) begin
            if (trip[i]) begin
                m_safe[i] = 1'b1;
            end else if (amp_cmd[i] && wdata[29]) begin
                m_safe[i] = 1'b0;                           // re-enable clears latch
            end
            if (amp_cmd[i]) begin
                m_amp_en[i] = wdata[29];
            end
        end
        if (pwr_cmd) begin
            m_pwr = wdata[18];
        end
        if (req) begin
            m_valid = 1'b1;
        end else if (m_valid && ctl[0]) begin
            m_valid = 1'b0;                                 // transfer edge
        end
        rd = '0;                                            // unmapped reads
        if (raddr[15:12] == 4'd0 && rc == 0 && raddr[3:0] == 4'd0) begin
            rd = {4'd0, BOARD_ID, ctl[1], 4'd0, m_pwr, 6'd0, fault_n, m_safe, m_amp_en};
        end else if (raddr[15:12] == 4'd0 && rc >= 1 && rc <= 4 && raddr[3:0] == 4'd1) begin
            rd = {16'd0, m_cur[rc - 1]};
        end else if (raddr[15:12] == 4'd0 && rc >= 1 && rc <= 4 && raddr[3:0] == 4'd12) begin
            rd = {2'd0, m_amp_en[rc - 1], 11'd0, m_safe[rc - 1], fault_n[rc - 1], 16'd0};
        end
        s = '{wmode: wmode, waddr: waddr, wdata: wdata, raddr: raddr, fault_n: fault_n,
              ctl: ctl, exp_rdata: rd,
              exp_amp_dis: ~({4{m_pwr}} & m_amp_en & ~m_safe),
              exp_flags: {m_pwr, pwr_cmd || (|amp_cmd), m_valid},
              exp_dac: {m_cur[3], m_cur[2], m_cur[1], m_cur[0]}};
        steps.push_back(s);
        names.push_back(name);
    endtask

    // ------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------
    task automatic build_table();
        foreach (m_cur[i]) m_cur[i] = '0;                   // model reset state
        {m_amp_en, m_safe, m_pwr, m_valid} = '0;
        add_step("reset_status", W_NONE, 16'h0, 32'h0, reg_addr(0, 0), PIN_OK, C_IDLE);
        add_step("reset_amp1", W_NONE, 16'h0, 32'h0, reg_addr(1, 12), PIN_OK, C_IDLE);
        for (int ch = 1; ch <= 4; ch++) begin
            add_step($sformatf("cur_write_ch%0d", ch), W_SGL, reg_addr(ch, 1), rand_word(),
                     reg_addr(ch, 1), PIN_OK, C_IDLE);
        end
        // same channel and offset as axis 1, but another block
        add_step("other_block", W_NONE, 16'h0, 32'h0, 16'h1011, PIN_OK, C_IDLE);
        add_step("cur_ch0", W_SGL, reg_addr(0, 1), rand_word(), reg_addr(0, 1), PIN_OK, C_IDLE);
        add_step("cur_ch5", W_SGL, reg_addr(5, 1), rand_word(), reg_addr(5, 1), PIN_OK, C_IDLE);
        add_step("cur_ch3_kept", W_NONE, 16'h0, 32'h0, reg_addr(3, 1), PIN_OK, C_IDLE);
        // amp gating on board power
        add_step("amp_no_pwr", W_SGL, reg_addr(2, 12), AMP_ON, reg_addr(2, 12), PIN_OK, C_IDLE);
        add_step("wclr_low", W_NONE, 16'h0, 32'h0, reg_addr(0, 0), PIN_OK, C_IDLE);
        add_step("pwr_on", W_SGL, reg_addr(0, 0), PWR_ON, reg_addr(0, 0), PIN_OK, C_IDLE);
        add_step("amp2_only", W_NONE, 16'h0, 32'h0, reg_addr(2, 12), PIN_OK, C_IDLE);
        add_step("amp3_on", W_SGL, reg_addr(3, 12), AMP_ON, reg_addr(0, 0), PIN_OK, C_IDLE);
        add_step("amp3_off", W_SGL, reg_addr(3, 12), AMP_OFF, reg_addr(3, 12), PIN_OK, C_IDLE);
        add_step("amp_no_mask", W_SGL, reg_addr(2, 12), 32'h0, reg_addr(2, 12), PIN_OK, C_IDLE);
        // safety latch
        add_step("fault2", W_NONE, 16'h0, 32'h0, reg_addr(2, 12), 4'b1101, C_IDLE);
        add_step("fault2_gone", W_NONE, 16'h0, 32'h0, reg_addr(2, 12), PIN_OK, C_IDLE);
        add_step("fault4_amp_off", W_NONE, 16'h0, 32'h0, reg_addr(0, 0), 4'b0111, C_IDLE);
        add_step("reenable2", W_SGL, reg_addr(2, 12), AMP_ON, reg_addr(2, 12), PIN_OK, C_IDLE);
        add_step("wdog_trip", W_NONE, 16'h0, 32'h0, reg_addr(0, 0), PIN_OK, C_WDOG);
        add_step("wdog_gone", W_NONE, 16'h0, 32'h0, reg_addr(0, 0), PIN_OK, C_IDLE);
        add_step("reenable2b", W_SGL, reg_addr(2, 12), AMP_ON, reg_addr(2, 12), PIN_OK, C_IDLE);
        // dac request and back-pressure
        add_step("blk_write1", W_BLK, reg_addr(1, 1), rand_word(),
                 reg_addr(1, 1), PIN_OK, C_IDLE);
        add_step("dac_hold", W_NONE, 16'h0, 32'h0, reg_addr(1, 1), PIN_OK, C_IDLE);
        add_step("blk_pending", W_BLK, reg_addr(4, 1), rand_word(),
                 reg_addr(4, 1), PIN_OK, C_IDLE);
        add_step("sgl_pending", W_SGL, reg_addr(3, 1), rand_word(),
                 reg_addr(3, 1), PIN_OK, C_IDLE);
        add_step("dac_xfer", W_NONE, 16'h0, 32'h0, reg_addr(3, 1), PIN_OK, C_RDY);
        add_step("dac_idle", W_NONE, 16'h0, 32'h0, reg_addr(3, 1), PIN_OK, C_RDY);
        add_step("blk_on_ready", W_BLK, reg_addr(2, 1), rand_word(),
                 reg_addr(2, 1), PIN_OK, C_RDY);
        add_step("blk_on_xfer", W_BLK, reg_addr(1, 1), rand_word(),
                 reg_addr(1, 1), PIN_OK, C_RDY);
        add_step("dac_xfer2", W_NONE, 16'h0, 32'h0, reg_addr(1, 1), PIN_OK, C_RDY);
        add_step("pwr_off", W_SGL, reg_addr(0, 0), PWR_OFF, reg_addr(0, 0), PIN_OK, C_IDLE);
    endtask

    // run limit far above one cycle per step
    always @(posedge sysclk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the step table did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        step_t s;

        reg_wr       = '0;
        reg_raddr    = '0;
        amp_fault_n  = PIN_OK;
        wdog_timeout = 1'b0;
        dac_ready    = 1'b0;
        board_id     = BOARD_ID;
        lfsr         = 16'd13;                              // seed
        build_table();
        cycle_limit = steps.size() * 8 + 32;                // reset plus margin
        @(posedge rst_n);                                   // released on a falling edge
        for (int k = 0; k < steps.size(); k++) begin
            s = steps[k];
            reg_wr = '{waddr: s.waddr, wdata: s.wdata, wen: s.wmode[1], blk_wen: s.wmode[0]};
            reg_raddr    = s.raddr;
            amp_fault_n  = s.fault_n;
            {wdog_timeout, dac_ready} = s.ctl;
            @(negedge sysclk);                              // one rising edge in between
            compare({names[k], " rdata"}, 64'(s.exp_rdata), 64'(reg_rdata));
            compare({names[k], " amp_disable"}, 64'(s.exp_amp_dis), 64'(amp_disable));
            compare({names[k], " pwr/wclr/valid"}, 64'(s.exp_flags),
                    64'({pwr_enable, wdog_clear, dac_valid}));
            compare({names[k], " dac_data"}, s.exp_dac, 64'(dac_data));
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
